// File: all.f
+incdir+design
design/cpu_pkg.sv
design/alu.sv
design/regfile.sv
design/program_counter.sv
design/instruction_register.sv
design/control_and_decoder.sv
design/dual_port_ram.sv
design/cpu_top.sv
testbench/tb_cpu_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile the cpu testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu_top -f all.f -o sim_cpu \
	&& ./obj_dir/sim_cpu > sim.log 2>&1 \
	|| { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "ALL CHECKS PASSED" sim.log \
	&& echo "simulation result: pass" \
	|| { echo "simulation result: fail"; exit 1; }

// File: testbench/tb_cpu_top.sv
`include "cpu_settings.svh"

module tb_cpu_top;

	localparam int RESET_CYCLES = 8;
	localparam int RAND_INSTRS = 200; // random part of the program
	localparam int DATA_BASE = 512;
	localparam int DATA_WORDS = 32; // preloaded data region
	localparam int NUM_TESTS = 6;
	localparam int T_RESET = 0;
	localparam int T_ALU = 1;
	localparam int T_MEM = 2;
	localparam int T_BRANCH = 3;
	localparam int T_TIMING = 4;
	localparam int T_END = 5;

	logic clk;
	logic reset;
	logic run;
	logic prog_we;
	cpu_pkg::addr_t prog_addr;
	cpu_pkg::word_t prog_data;
	cpu_pkg::word_t out;
	logic retire;
	cpu_pkg::addr_t pc;
	cpu_pkg::flags_t flags;

	// instruction set model state
	logic [15:0] m_mem [`CPU_MEM_DEPTH];
	logic [15:0] m_reg [`CPU_NUM_REGS];
	logic [15:0] m_pc;
	logic [4:0] m_flags; // n c v z l
	logic [15:0] m_out;
	logic [15:0] cur_pc; // address of the instruction being checked

	logic [15:0] prog [$];
	int prog_len;
	int readback_addr; // first of the final mov readbacks
	int end_addr; // branch to self
	int seed;
	int cyc;
	int last_retire;
	int checks [NUM_TESTS];
	int errors [NUM_TESTS];
	string test_name [NUM_TESTS];
	int total_checks;
	int total_errors;

	cpu_top u_dut (
		.clk(clk), .reset(reset), .run(run),
		.prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
		.out(out), .retire(retire), .pc(pc), .flags(flags)
	);

	always #4 clk = ~clk; // period 8

	function automatic logic [15:0] encode(input logic [3:0] op, input logic [3:0] rd,
		input logic [7:0] low);
		return {op, rd, low};
	endfunction

	// odd multiplier so every address bit moves the word
	function automatic logic [15:0] fill_word(input int addr);
		return 16'(addr * 40503) ^ 16'h5a5a;
	endfunction

	task automatic check_value(input int cat, input string name, input logic [15:0] got,
		input logic [15:0] exp);
		checks[cat]++;
		assert (got === exp) else begin
			$display("Fail %s: got %h expected %h at pc %h", name, got, exp, cur_pc);
			errors[cat]++;
		end
	endtask

	task automatic build_program();
		int r;
		int idx;
		int rand_end;
		int disp;
		int target;
		logic [3:0] op;
		logic [3:0] rd;
		logic [3:0] cond;
		bit hop_to [`CPU_MEM_DEPTH]; // addresses some branch lands on
		// bases r12..r15 = 512, 516, 520, 524
		prog.push_back(encode(cpu_pkg::MOVI, 4'd15, 8'd9));
		prog.push_back(encode(cpu_pkg::MOVI, 4'd12, 8'd1));
		prog.push_back(encode(cpu_pkg::SHIFT, 4'd12, 8'd15)); // 1 << 9
		prog.push_back(encode(cpu_pkg::MOV, 4'd13, 8'd12));
		prog.push_back(encode(cpu_pkg::ADDI, 4'd13, 8'd4));
		prog.push_back(encode(cpu_pkg::MOV, 4'd14, 8'd13));
		prog.push_back(encode(cpu_pkg::ADDI, 4'd14, 8'd4));
		prog.push_back(encode(cpu_pkg::MOV, 4'd15, 8'd14));
		prog.push_back(encode(cpu_pkg::ADDI, 4'd15, 8'd4));
		prog.push_back(encode(cpu_pkg::MOVI, 4'd1, 8'ha5)); // store then load same word
		prog.push_back(encode(cpu_pkg::STOR, 4'd1, 8'd12));
		prog.push_back(encode(cpu_pkg::LOAD, 4'd2, 8'd12));
		rand_end = prog.size() + RAND_INSTRS;
		while (prog.size() < rand_end) begin
			idx = prog.size();
			r = $random(seed);
			op = r[15:12];
			rd = r[27:24] % 4'd12; // random writes stay off the bases
			case (op)
				cpu_pkg::LOAD: prog.push_back(encode(op, rd, {6'd0, 2'b11, r[1:0]}));
				cpu_pkg::STOR: prog.push_back(encode(op, r[27:24], {6'd0, 2'b11, r[1:0]}));
				cpu_pkg::BRANCH: begin
					cond = r[27:24] % 4'd9;
					// jr needs room for its pair and a movi that no hop skips
					if (cond == 4'd8 && (idx + 2 > rand_end || hop_to[idx + 1]))
						cond = 4'd7;
					if (cond == 4'd8) begin
						target = idx + 2 + int'(r[5:4]); // short forward hop
						if (target > rand_end)
							target = rand_end;
						hop_to[target] = 1'b1;
						prog.push_back(encode(cpu_pkg::MOVI, 4'd11, 8'(target)));
						prog.push_back(encode(op, cond, 8'd11));
					end else begin
						disp = int'(r[5:4]);
						if (idx + 1 + disp > rand_end)
							disp = rand_end - idx - 1; // never skip the readbacks
						hop_to[idx + 1 + disp] = 1'b1;
						prog.push_back(encode(op, cond, 8'(disp)));
					end
				end
				default: prog.push_back(encode(op, rd, r[7:0])); // alu op with rsrc in low nibble
			endcase
		end
		readback_addr = prog.size();
		for (int i = 0; i < `CPU_NUM_REGS; i++)
			prog.push_back(encode(cpu_pkg::MOV, 4'(i), 8'(i))); // out shows r[i]
		end_addr = prog.size();
		prog.push_back(encode(cpu_pkg::BRANCH, cpu_pkg::AL, 8'hff));
		prog_len = prog.size();
	endtask

	task automatic load_word(input int addr, input logic [15:0] data);
		@(posedge clk);
		#1;
		prog_we = 1'b1;
		prog_addr = 16'(addr);
		prog_data = data;
		m_mem[addr] = data; // mirror
		check_value(T_RESET, "pc", pc, 16'h0); // idle while run low
		check_value(T_RESET, "retire", {15'd0, retire}, 16'h0);
	endtask

	// steps the model by one instruction and picks the test it counts for
	task automatic model_step(input logic [15:0] ins, output int cat);
		logic [3:0] op;
		logic [3:0] rd;
		logic [7:0] imm;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] res;
		logic [16:0] wide;
		logic [15:0] next_pc;
		logic cin;
		logic take;
		logic is_alu;
		int sres;
		op = ins[15:12];
		rd = ins[11:8];
		imm = ins[7:0];
		a = m_reg[rd];
		b = m_reg[ins[3:0]];
		if (op == cpu_pkg::ADDI || op == cpu_pkg::SUBI || op == cpu_pkg::CMPI ||
			op == cpu_pkg::MOVI)
			b = {8'd0, imm}; // zero extended
		is_alu = (op != cpu_pkg::LOAD) && (op != cpu_pkg::STOR) && (op != cpu_pkg::BRANCH);
		next_pc = m_pc + 16'd1;
		res = 16'd0;
		cat = T_ALU;
		case (op)
			cpu_pkg::ADD, cpu_pkg::ADDI, cpu_pkg::ADDC: begin
				cin = (op == cpu_pkg::ADDC) ? m_flags[3] : 1'b0;
				wide = {1'b0, a} + {1'b0, b} + 17'(cin);
				sres = int'($signed(a)) + int'($signed(b)) + int'(cin);
				res = wide[15:0];
				m_flags[3] = wide[16];
				m_flags[2] = (sres > 32767) || (sres < -32768);
				m_flags[0] = 1'b0;
			end
			cpu_pkg::SUB, cpu_pkg::SUBI, cpu_pkg::CMP, cpu_pkg::CMPI: begin
				res = a - b;
				sres = int'($signed(a)) - int'($signed(b));
				m_flags[3] = (a >= b); // carry means no borrow
				m_flags[2] = (sres > 32767) || (sres < -32768);
				m_flags[0] = (a < b);
			end
			cpu_pkg::AND: res = a & b;
			cpu_pkg::OR: res = a | b;
			cpu_pkg::XOR: res = a ^ b;
			cpu_pkg::MOV, cpu_pkg::MOVI: res = b;
			cpu_pkg::SHIFT: res = b[15] ? (a >> b[3:0]) : (a << b[3:0]);
			cpu_pkg::LOAD: begin
				cat = T_MEM;
				res = m_mem[b[9:0]];
			end
			cpu_pkg::STOR: begin
				cat = T_MEM;
				m_mem[b[9:0]] = a;
			end
			default: begin
				cat = T_BRANCH;
				case (rd)
					cpu_pkg::EQ: take = m_flags[1];
					cpu_pkg::NE: take = !m_flags[1];
					cpu_pkg::CS: take = m_flags[3];
					cpu_pkg::CC: take = !m_flags[3];
					cpu_pkg::LO: take = m_flags[0];
					cpu_pkg::HS: take = !m_flags[0];
					cpu_pkg::MI: take = m_flags[4];
					cpu_pkg::AL: take = 1'b1;
					default: take = 1'b0;
				endcase
				if (rd == cpu_pkg::JR)
					next_pc = b;
				else if (take)
					next_pc = m_pc + 16'd1 + {{8{imm[7]}}, imm};
			end
		endcase
		if (is_alu) begin
			m_flags[4] = res[15];
			m_flags[1] = (res == 16'd0);
		end
		if ((is_alu && op != cpu_pkg::CMP && op != cpu_pkg::CMPI) || op == cpu_pkg::LOAD) begin
			m_reg[rd] = res;
			m_out = res;
		end
		m_pc = next_pc;
		if (cur_pc >= 16'(readback_addr))
			cat = T_END;
	endtask

	// follow retire pulses until the branch to self retires
	task automatic run_program();
		logic [15:0] ins;
		int cat;
		int len;
		bit done;
		done = 1'b0;
		while (!done) begin
			@(negedge clk); // outputs settled here
			cyc++;
			if (retire) begin
				cur_pc = m_pc;
				ins = m_mem[m_pc[9:0]];
				len = (ins[15:12] == cpu_pkg::LOAD) ? 4 : 3;
				if (last_retire >= 0)
					check_value(T_TIMING, "retire spacing", 16'(cyc - last_retire), 16'(len));
				last_retire = cyc;
				done = (m_pc == 16'(end_addr));
				model_step(ins, cat);
				@(negedge clk); // out, pc, flags update after retire
				cyc++;
				check_value(cat, "out", out, m_out);
				check_value(cat, "pc", pc, m_pc);
				check_value(cat, "flags", {11'd0, flags}, {11'd0, m_flags});
			end
		end
		check_value(T_END, "final pc", pc, 16'(end_addr));
	endtask

	task automatic report_test(input int t);
		$display("%s: %0d checks, %0d errors", test_name[t], checks[t], errors[t]);
	endtask

	// watchdog covers load time plus four cycles per word and a margin
	initial begin
		wait (prog_len != 0);
		repeat (RESET_CYCLES + prog_len + DATA_WORDS + 4 * prog_len + 100) @(posedge clk);
		$display("timeout: the program never reached its final branch to self");
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		clk = 1'b0;
		reset = 1'b0;
		run = 1'b0;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		seed = 12;
		cyc = 0;
		last_retire = -1; // first spacing depends on run
		cur_pc = '0;
		test_name[T_RESET] = "reset_state";
		test_name[T_ALU] = "alu_ops";
		test_name[T_MEM] = "memory_access";
		test_name[T_BRANCH] = "branches";
		test_name[T_TIMING] = "instruction_timing";
		test_name[T_END] = "program_end";
		for (int i = 0; i < NUM_TESTS; i++) begin
			checks[i] = 0;
			errors[i] = 0;
		end
		for (int i = 0; i < `CPU_MEM_DEPTH; i++)
			m_mem[i] = 16'd0;
		for (int i = 0; i < `CPU_NUM_REGS; i++)
			m_reg[i] = 16'd0;
		m_pc = 16'd0;
		m_flags = 5'd0;
		m_out = 16'd0;
		build_program();
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b1;
		for (int i = 0; i < prog_len; i++)
			load_word(i, prog[i]);
		for (int i = DATA_BASE; i < DATA_BASE + DATA_WORDS; i++)
			load_word(i, fill_word(i));
		@(posedge clk);
		#1;
		prog_we = 1'b0;
		report_test(T_RESET);
		run = 1'b1;
		run_program();
		total_checks = 0;
		total_errors = 0;
		for (int t = 1; t < NUM_TESTS; t++)
			report_test(t);
		for (int t = 0; t < NUM_TESTS; t++) begin
			total_checks += checks[t];
			total_errors += errors[t];
		end
		$display("total: %0d checks, %0d errors", total_checks, total_errors);
		if (total_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: design/cpu_top.sv
`include "cpu_settings.svh"

module cpu_top (
	input logic clk,
	input logic reset,
	input logic run,
	input logic prog_we,
	input cpu_pkg::addr_t prog_addr,
	input cpu_pkg::word_t prog_data,
	output cpu_pkg::word_t out, // last written value
	output logic retire,
	output cpu_pkg::addr_t pc,
	output cpu_pkg::flags_t flags
);

	// controls
	logic ir_en, pc_en, imm_sel, wb_sel, addr_sel, mem_we, flag_we;
	cpu_pkg::pc_sel_t pc_sel;
	logic [`CPU_NUM_REGS-1:0] reg_en;

	// instruction fields
	cpu_pkg::opcode_t op;
	cpu_pkg::reg_idx_t rdest;
	cpu_pkg::reg_idx_t rsrc;
	cpu_pkg::imm8_t imm8;

	cpu_pkg::word_t rdata_a; // rdest register, store data
	cpu_pkg::word_t rdata_b; // rsrc register, address or operand
	cpu_pkg::word_t alu_b;
	cpu_pkg::word_t alu_out;
	cpu_pkg::word_t wb_data;
	cpu_pkg::word_t q_a;
	cpu_pkg::addr_t mem_addr;
	cpu_pkg::flags_t flags_next;

	// the three datapath selects
	assign mem_addr = addr_sel ? rdata_b : pc;
	assign alu_b = imm_sel ? cpu_pkg::word_t'(imm8) : rdata_b; // zero extend
	assign wb_data = wb_sel ? q_a : alu_out;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			flags <= '0;
			out <= '0;
		end else begin
			if (flag_we)
				flags <= flags_next; // alu ops only
			if (|reg_en)
				out <= wb_data; // cmp, store, branch keep it
		end
	end

	control_and_decoder u_ctrl (
		.clk(clk), .reset(reset), .run(run),
		.op(op), .rdest(rdest), .flags(flags),
		.ir_en(ir_en), .pc_en(pc_en), .pc_sel(pc_sel), .reg_en(reg_en),
		.imm_sel(imm_sel), .wb_sel(wb_sel), .addr_sel(addr_sel),
		.mem_we(mem_we), .flag_we(flag_we), .retire(retire)
	);

	instruction_register u_ir (
		.clk(clk), .reset(reset), .ir_en(ir_en), .mem_data(q_a),
		.op(op), .rdest(rdest), .rsrc(rsrc), .imm8(imm8)
	);

	program_counter u_pc (
		.clk(clk), .reset(reset), .pc_en(pc_en), .pc_sel(pc_sel),
		.disp(imm8), .jump_addr(rdata_b), .pc(pc)
	);

	regfile u_regs (
		.clk(clk), .reset(reset), .wdata(wb_data), .reg_en(reg_en),
		.raddr_a(rdest), .raddr_b(rsrc), .rdata_a(rdata_a), .rdata_b(rdata_b)
	);

	alu u_alu (
		.a(rdata_a), .b(alu_b), .op(op), .flags_in(flags),
		.result(alu_out), .flags_next(flags_next)
	);

	// port b belongs to the program loader
	dual_port_ram u_ram (
		.clk(clk),
		.addr_a(mem_addr[`CPU_MEM_AW-1:0]), .data_a(rdata_a), .we_a(mem_we), .q_a(q_a),
		.addr_b(prog_addr[`CPU_MEM_AW-1:0]), .data_b(prog_data), .we_b(prog_we)
	);

endmodule

// File: design/dual_port_ram.sv
`include "cpu_settings.svh"

module dual_port_ram (
	input logic clk,
	input logic [`CPU_MEM_AW-1:0] addr_a, // fetch, load, store
	input cpu_pkg::word_t data_a,
	input logic we_a,
	output cpu_pkg::word_t q_a,
	input logic [`CPU_MEM_AW-1:0] addr_b, // program load
	input cpu_pkg::word_t data_b,
	input logic we_b
);

	cpu_pkg::word_t mem [`CPU_MEM_DEPTH];

	// port b is write only
	always_ff @(posedge clk) begin
		if (we_a)
			mem[addr_a] <= data_a; // store from the cpu
		if (we_b)
			mem[addr_b] <= data_b; // program load
		q_a <= mem[addr_a]; // old word on a write
	end

endmodule

// File: design/control_and_decoder.sv
`include "cpu_settings.svh"

module control_and_decoder (
	input logic clk,
	input logic reset,
	input logic run, // low holds the machine in fetch
	input cpu_pkg::opcode_t op,
	input cpu_pkg::reg_idx_t rdest,
	input cpu_pkg::flags_t flags, // stored flags for branch conditions
	output logic ir_en,
	output logic pc_en,
	output cpu_pkg::pc_sel_t pc_sel,
	output logic [`CPU_NUM_REGS-1:0] reg_en,
	output logic imm_sel, // alu operand b from imm8
	output logic wb_sel, // write back from memory
	output logic addr_sel, // port a address from rsrc register
	output logic mem_we,
	output logic flag_we,
	output logic retire
);

	cpu_pkg::ctrl_state_t state;
	cpu_pkg::ctrl_state_t state_next;
	cpu_pkg::cond_t cond;
	logic [`CPU_NUM_REGS-1:0] reg_onehot;
	logic is_imm;
	logic is_mem;
	logic alu_writes;
	logic alu_flags;
	logic taken;

	assign cond = cpu_pkg::cond_t'(rdest);
	assign reg_onehot = {{(`CPU_NUM_REGS-1){1'b0}}, 1'b1} << rdest;

	// opcode classes
	assign is_imm = (op == cpu_pkg::ADDI) || (op == cpu_pkg::SUBI) ||
		(op == cpu_pkg::CMPI) || (op == cpu_pkg::MOVI);
	assign is_mem = (op == cpu_pkg::LOAD) || (op == cpu_pkg::STOR);
	assign alu_flags = !is_mem && (op != cpu_pkg::BRANCH); // every alu op
	assign alu_writes = alu_flags && (op != cpu_pkg::CMP) && (op != cpu_pkg::CMPI);

	// condition check on stored flags, jr handled apart
	always_comb begin
		case (cond)
			cpu_pkg::EQ: taken = flags[cpu_pkg::FLAG_Z];
			cpu_pkg::NE: taken = !flags[cpu_pkg::FLAG_Z];
			cpu_pkg::CS: taken = flags[cpu_pkg::FLAG_C];
			cpu_pkg::CC: taken = !flags[cpu_pkg::FLAG_C];
			cpu_pkg::LO: taken = flags[cpu_pkg::FLAG_L];
			cpu_pkg::HS: taken = !flags[cpu_pkg::FLAG_L];
			cpu_pkg::MI: taken = flags[cpu_pkg::FLAG_N];
			cpu_pkg::AL: taken = 1'b1;
			default: taken = 1'b0; // unused codes fall through
		endcase
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset)
			state <= cpu_pkg::FETCH;
		else
			state <= state_next;
	end

	always_comb begin
		case (state)
			cpu_pkg::FETCH: state_next = run ? cpu_pkg::DECODE : cpu_pkg::FETCH;
			cpu_pkg::DECODE: state_next = cpu_pkg::EXECUTE;
			cpu_pkg::EXECUTE: begin
				if (op == cpu_pkg::LOAD)
					state_next = cpu_pkg::MEMORY; // wait for read data
				else
					state_next = cpu_pkg::FETCH;
			end
			default: state_next = cpu_pkg::FETCH;
		endcase
	end

	// datapath controls
	always_comb begin
		ir_en = 1'b0;
		pc_sel = cpu_pkg::PC_INC;
		reg_en = '0;
		imm_sel = is_imm; // harmless outside execute
		wb_sel = 1'b0;
		addr_sel = 1'b0; // pc addresses memory in fetch
		mem_we = 1'b0;
		flag_we = 1'b0;
		retire = 1'b0;
		case (state)
			cpu_pkg::DECODE: ir_en = 1'b1; // read data arrives now
			cpu_pkg::EXECUTE: begin
				addr_sel = is_mem;
				mem_we = (op == cpu_pkg::STOR);
				flag_we = alu_flags;
				if (alu_writes)
					reg_en = reg_onehot;
				retire = (op != cpu_pkg::LOAD);
				if (op == cpu_pkg::BRANCH) begin
					if (cond == cpu_pkg::JR)
						pc_sel = cpu_pkg::PC_ABS;
					else if (taken)
						pc_sel = cpu_pkg::PC_REL;
				end
			end
			cpu_pkg::MEMORY: begin
				wb_sel = 1'b1; // load data from port a
				reg_en = reg_onehot;
				retire = 1'b1;
			end
			default: ;
		endcase
		pc_en = retire; // pc moves once per instruction
	end

endmodule

// File: design/instruction_register.sv
module instruction_register (
	input logic clk,
	input logic reset,
	input logic ir_en, // decode cycle
	input cpu_pkg::word_t mem_data, // port a read data
	output cpu_pkg::opcode_t op,
	output cpu_pkg::reg_idx_t rdest,
	output cpu_pkg::reg_idx_t rsrc,
	output cpu_pkg::imm8_t imm8
);

	cpu_pkg::word_t ir;

	// held through execute and memory
	always_ff @(posedge clk or negedge reset) begin
		if (!reset)
			ir <= '0;
		else if (ir_en)
			ir <= mem_data;
	end

	assign op = cpu_pkg::opcode_t'(ir[15:12]);
	assign rdest = ir[11:8]; // also branch condition
	assign rsrc = ir[3:0]; // overlaps imm8 low nibble
	assign imm8 = ir[7:0];

endmodule

// File: design/program_counter.sv
module program_counter (
	input logic clk,
	input logic reset,
	input logic pc_en, // advance on retire only
	input cpu_pkg::pc_sel_t pc_sel,
	input cpu_pkg::imm8_t disp, // branch offset, signed
	input cpu_pkg::addr_t jump_addr, // jr target from the rsrc register
	output cpu_pkg::addr_t pc
);

	cpu_pkg::addr_t pc_inc;
	cpu_pkg::addr_t disp_ext;

	assign pc_inc = pc + 1'b1; // address of the following instruction
	assign disp_ext = cpu_pkg::addr_t'($signed(disp));

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			pc <= '0;
		end else if (pc_en) begin
			case (pc_sel)
				cpu_pkg::PC_INC: pc <= pc_inc;
				cpu_pkg::PC_REL: pc <= pc_inc + disp_ext; // relative to next instr
				cpu_pkg::PC_ABS: pc <= jump_addr;
				default: pc <= pc_inc;
			endcase
		end
	end

endmodule

// File: design/regfile.sv
`include "cpu_settings.svh"

module regfile (
	input logic clk,
	input logic reset,
	input cpu_pkg::word_t wdata,
	input logic [`CPU_NUM_REGS-1:0] reg_en, // one hot, all zero means no write
	input cpu_pkg::reg_idx_t raddr_a,
	input cpu_pkg::reg_idx_t raddr_b,
	output cpu_pkg::word_t rdata_a,
	output cpu_pkg::word_t rdata_b
);

	cpu_pkg::word_t regs [`CPU_NUM_REGS];

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < `CPU_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 0; i < `CPU_NUM_REGS; i++) begin
				if (reg_en[i])
					regs[i] <= wdata; // each register has its own enable
			end
		end
	end

	// combinational reads, new value visible next cycle
	assign rdata_a = regs[raddr_a];
	assign rdata_b = regs[raddr_b];

endmodule

// File: design/alu.sv
`include "cpu_settings.svh"

module alu (
	input cpu_pkg::word_t a, // rdest register
	input cpu_pkg::word_t b, // rsrc register or immediate
	input cpu_pkg::opcode_t op,
	input cpu_pkg::flags_t flags_in, // stored flags
	output cpu_pkg::word_t result,
	output cpu_pkg::flags_t flags_next
);

	logic [`CPU_DATA_W:0] sum; // top bit is carry out
	logic [`CPU_DATA_W:0] diff; // top bit set means no borrow
	logic cin;
	logic add_ovf;
	logic sub_ovf;
	logic [3:0] shamt;

	// only addc chains the stored carry
	assign cin = (op == cpu_pkg::ADDC) ? flags_in[cpu_pkg::FLAG_C] : 1'b0;

	assign sum = {1'b0, a} + {1'b0, b} + {{`CPU_DATA_W{1'b0}}, cin};
	assign diff = {1'b0, a} + {1'b0, ~b} + {{`CPU_DATA_W{1'b0}}, 1'b1}; // a - b

	// same signs in, different sign out
	assign add_ovf = (a[`CPU_DATA_W-1] == b[`CPU_DATA_W-1]) &&
		(sum[`CPU_DATA_W-1] != a[`CPU_DATA_W-1]);
	assign sub_ovf = (a[`CPU_DATA_W-1] != b[`CPU_DATA_W-1]) &&
		(diff[`CPU_DATA_W-1] != a[`CPU_DATA_W-1]);

	assign shamt = b[3:0];

	always_comb begin
		flags_next = flags_in; // c, v, l held unless arithmetic
		result = a;
		case (op)
			cpu_pkg::ADD, cpu_pkg::ADDI, cpu_pkg::ADDC: begin
				result = sum[`CPU_DATA_W-1:0];
				flags_next[cpu_pkg::FLAG_C] = sum[`CPU_DATA_W];
				flags_next[cpu_pkg::FLAG_V] = add_ovf;
				flags_next[cpu_pkg::FLAG_L] = 1'b0; // no compare on add
			end
			cpu_pkg::SUB, cpu_pkg::SUBI, cpu_pkg::CMP, cpu_pkg::CMPI: begin
				result = diff[`CPU_DATA_W-1:0]; // cmp result is dropped upstream
				flags_next[cpu_pkg::FLAG_C] = diff[`CPU_DATA_W];
				flags_next[cpu_pkg::FLAG_V] = sub_ovf;
				flags_next[cpu_pkg::FLAG_L] = ~diff[`CPU_DATA_W]; // borrow = a < b
			end
			cpu_pkg::AND: result = a & b;
			cpu_pkg::OR: result = a | b;
			cpu_pkg::XOR: result = a ^ b;
			cpu_pkg::MOV, cpu_pkg::MOVI: result = b;
			cpu_pkg::SHIFT: begin
				// direction from the sign bit of the amount register
				if (b[`CPU_DATA_W-1])
					result = a >> shamt;
				else
					result = a << shamt;
			end
			default: result = a; // load, store, branch never write flags
		endcase
		// n and z track every result
		flags_next[cpu_pkg::FLAG_N] = result[`CPU_DATA_W-1];
		flags_next[cpu_pkg::FLAG_Z] = (result == '0);
	end

endmodule

// File: design/cpu_pkg.sv
`include "cpu_settings.svh"

package cpu_pkg;

	typedef logic [`CPU_DATA_W-1:0] word_t; // data word
	typedef logic [`CPU_DATA_W-1:0] addr_t; // full address, memory sees low bits only
	typedef logic [$clog2(`CPU_NUM_REGS)-1:0] reg_idx_t;
	typedef logic [7:0] imm8_t; // low byte of the instruction
	typedef logic [4:0] flags_t; // {n, c, v, z, l}

	// bit positions inside flags_t
	localparam int FLAG_N = 4; // negative
	localparam int FLAG_C = 3; // carry, no borrow on subtract
	localparam int FLAG_V = 2; // signed overflow
	localparam int FLAG_Z = 1; // zero
	localparam int FLAG_L = 0; // unsigned less

	// instruction bits 15..12
	typedef enum logic [3:0] {
		ADD, ADDI, ADDC, SUB,
		SUBI, CMP, CMPI, AND,
		OR, XOR, MOV, MOVI,
		SHIFT, LOAD, STOR, BRANCH
	} opcode_t;

	// branch condition, sits in the rdest field
	typedef enum logic [3:0] {
		EQ = 4'd0, // z set
		NE = 4'd1, // z clear
		CS = 4'd2, // c set
		CC = 4'd3, // c clear
		LO = 4'd4, // l set
		HS = 4'd5, // l clear
		MI = 4'd6, // n set
		AL = 4'd7, // always
		JR = 4'd8 // absolute, target in rsrc register
	} cond_t;

	typedef enum logic [1:0] {
		FETCH,
		DECODE,
		EXECUTE,
		MEMORY // load only
	} ctrl_state_t;

	// next pc source
	typedef enum logic [1:0] {
		PC_INC, // pc + 1
		PC_REL, // pc + 1 + sign extended displacement
		PC_ABS // register target
	} pc_sel_t;

endpackage

// File: design/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// word width of registers, alu and memory
`define CPU_DATA_W 16

// words in the shared program and data memory
`define CPU_MEM_DEPTH 1024

// low address bits that reach the memory
`define CPU_MEM_AW 10

// general purpose registers, one write enable each
`define CPU_NUM_REGS 16

`endif
